// File: verilog/mem_cfg_pkg.sv
// memory geometry
// 64 KiB of byte-addressed RAM split into four word-wide banks

package mem_cfg_pkg;

   // bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // bank number lives in the top address bits
   localparam int NUM_BANKS  = 4;
   localparam int BANK_SEL_W = 2;

   // word index inside a bank, address bits 13..1
   localparam int WORD_IDX_W = 13;
   localparam int BANK_WORDS = 1 << WORD_IDX_W;

   // lowest address bit of the bank number
   localparam int BANK_LSB = ADDR_W - BANK_SEL_W;

endpackage

// File: verilog/bus_op_pkg.sv
// bus access kinds
// one code per cycle as seen by the decoder and the read path

package bus_op_pkg;

   typedef enum logic [2:0]
   {
      OP_IDLE,
      OP_READ_WORD,
      OP_READ_BYTE_LO,
      OP_READ_BYTE_HI,
      OP_WRITE_WORD,
      OP_WRITE_BYTE_LO,
      OP_WRITE_BYTE_HI
   } bus_op_e;

endpackage

// File: verilog/bus_decode.sv
// bus decoder
// classifies each cycle, drives per-bank lane writes and read enables,
// and keeps a one-stage read descriptor for the steering logic

`timescale 1ns/1ps

module bus_decode
(
   input  logic                                  CLK,
   input  logic                                  rst_n,
   input  logic [mem_cfg_pkg::ADDR_W-1:0]        A,
   input  logic [mem_cfg_pkg::DATA_W-1:0]        DI,
   input  logic                                  CE_N,
   input  logic                                  WE_N,
   input  logic                                  BYTE_OP,
   output logic [mem_cfg_pkg::NUM_BANKS-1:0]     bank_rd_en,
   output logic [mem_cfg_pkg::NUM_BANKS-1:0]     bank_we_hi,
   output logic [mem_cfg_pkg::NUM_BANKS-1:0]     bank_we_lo,
   output logic [mem_cfg_pkg::WORD_IDX_W-1:0]    word_idx,
   output logic [mem_cfg_pkg::DATA_W-1:0]        wr_data,
   output bus_op_pkg::bus_op_e                   rd_op,
   output logic [mem_cfg_pkg::BANK_SEL_W-1:0]    rd_bank
);

   import mem_cfg_pkg::*;
   import bus_op_pkg::*;

   bus_op_e               op;
   logic [BANK_SEL_W-1:0] bank;
   logic [NUM_BANKS-1:0]  bank_sel;
   logic                  lane_hi;
   logic                  lane_lo;
   logic                  is_read;

   // cycle classification
   always_comb
   begin
      if (CE_N)
         op = OP_IDLE;
      else if (!WE_N)
      begin
         if (!BYTE_OP)
            op = OP_WRITE_WORD;
         else if (A[0])
            op = OP_WRITE_BYTE_HI;
         else
            op = OP_WRITE_BYTE_LO;
      end
      else
      begin
         if (!BYTE_OP)
            op = OP_READ_WORD;
         else if (A[0])
            op = OP_READ_BYTE_HI;
         else
            op = OP_READ_BYTE_LO;
      end
   end

   assign bank     = A[ADDR_W-1:BANK_LSB];
   assign word_idx = A[WORD_IDX_W:1];
   assign bank_sel = {{(NUM_BANKS-1){1'b0}}, 1'b1} << bank;

   assign lane_hi = (op == OP_WRITE_WORD) || (op == OP_WRITE_BYTE_HI);
   assign lane_lo = (op == OP_WRITE_WORD) || (op == OP_WRITE_BYTE_LO);
   assign is_read = (op == OP_READ_WORD) || (op == OP_READ_BYTE_LO) ||
                    (op == OP_READ_BYTE_HI);

   assign bank_we_hi = lane_hi ? bank_sel : '0;
   assign bank_we_lo = lane_lo ? bank_sel : '0;
   assign bank_rd_en = is_read ? bank_sel : '0;

   // byte writes carry DI[7:0] on whichever lane is enabled
   assign wr_data = BYTE_OP ? {DI[7:0], DI[7:0]} : DI;

   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_op   <= OP_IDLE;
         rd_bank <= '0;
      end
      else
      begin
         rd_op <= is_read ? op : OP_IDLE;
         if (is_read)
            rd_bank <= bank;
      end
   end

endmodule

// File: verilog/ram_bank.sv
// one RAM bank of 8192 words
// separate high and low byte arrays, lane writes, registered read

`timescale 1ns/1ps

module ram_bank
(
   input  logic                                  CLK,
   input  logic                                  rd_en,
   input  logic                                  we_hi,
   input  logic                                  we_lo,
   input  logic [mem_cfg_pkg::WORD_IDX_W-1:0]    word_idx,
   input  logic [mem_cfg_pkg::DATA_W-1:0]        wr_data,
   output logic [mem_cfg_pkg::DATA_W-1:0]        rd_data
);

   import mem_cfg_pkg::*;

   logic [7:0] mem_hi [BANK_WORDS];
   logic [7:0] mem_lo [BANK_WORDS];

   // high lane
   always_ff @(posedge CLK)
   begin
      if (we_hi)
         mem_hi[word_idx] <= wr_data[15:8];
   end

   // low lane
   always_ff @(posedge CLK)
   begin
      if (we_lo)
         mem_lo[word_idx] <= wr_data[7:0];
   end

   // read port, holds its word until the next read of this bank
   always_ff @(posedge CLK)
   begin
      if (rd_en)
         rd_data <= {mem_hi[word_idx], mem_lo[word_idx]};
   end

endmodule

// File: verilog/read_steer.sv
// read steering
// picks the registered bank word and aligns it for word or byte reads

`timescale 1ns/1ps

module read_steer
(
   input  bus_op_pkg::bus_op_e                                rd_op,
   input  logic [mem_cfg_pkg::BANK_SEL_W-1:0]                 rd_bank,
   input  logic [mem_cfg_pkg::NUM_BANKS*mem_cfg_pkg::DATA_W-1:0] bank_data,
   output logic [mem_cfg_pkg::DATA_W-1:0]                     DO
);

   import mem_cfg_pkg::*;
   import bus_op_pkg::*;

   logic [DATA_W-1:0] word;

   assign word = bank_data[rd_bank*DATA_W +: DATA_W];

   always_comb
   begin
      case (rd_op)
         OP_READ_WORD:
            DO = word;
         OP_READ_BYTE_LO:
            DO = {8'h00, word[7:0]};
         OP_READ_BYTE_HI:
            DO = {8'h00, word[15:8]};
         // idle and write cycles leave the bus at zero
         default:
            DO = '0;
      endcase
   end

endmodule

// File: verilog/mem_subsys.sv
// main memory subsystem
// 64 KiB static RAM on a 16-bit bus, four banks behind a decoder,
// one-cycle registered reads and same-edge writes

`timescale 1ns/1ps

module mem_subsys
(
   input  logic                              CLK,
   input  logic                              rst_n,
   input  logic [mem_cfg_pkg::ADDR_W-1:0]    A,
   input  logic [mem_cfg_pkg::DATA_W-1:0]    DI,
   input  logic                              CE_N,
   input  logic                              WE_N,
   input  logic                              BYTE_OP,
   output logic [mem_cfg_pkg::DATA_W-1:0]    DO
);

   import mem_cfg_pkg::*;
   import bus_op_pkg::*;

   logic [NUM_BANKS-1:0]        bank_rd_en;
   logic [NUM_BANKS-1:0]        bank_we_hi;
   logic [NUM_BANKS-1:0]        bank_we_lo;
   logic [WORD_IDX_W-1:0]       word_idx;
   logic [DATA_W-1:0]           wr_data;
   bus_op_e                     rd_op;
   logic [BANK_SEL_W-1:0]       rd_bank;
   logic [NUM_BANKS*DATA_W-1:0] bank_data;

   bus_decode u_decode
   (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .A          (A),
      .DI         (DI),
      .CE_N       (CE_N),
      .WE_N       (WE_N),
      .BYTE_OP    (BYTE_OP),
      .bank_rd_en (bank_rd_en),
      .bank_we_hi (bank_we_hi),
      .bank_we_lo (bank_we_lo),
      .word_idx   (word_idx),
      .wr_data    (wr_data),
      .rd_op      (rd_op),
      .rd_bank    (rd_bank)
   );

   // index and write data are shared, enables are per bank
   for (genvar g = 0; g < NUM_BANKS; g++)
   begin : g_bank
      ram_bank u_bank
      (
         .CLK      (CLK),
         .rd_en    (bank_rd_en[g]),
         .we_hi    (bank_we_hi[g]),
         .we_lo    (bank_we_lo[g]),
         .word_idx (word_idx),
         .wr_data  (wr_data),
         .rd_data  (bank_data[g*DATA_W +: DATA_W])
      );
   end

   read_steer u_steer
   (
      .rd_op     (rd_op),
      .rd_bank   (rd_bank),
      .bank_data (bank_data),
      .DO        (DO)
   );

endmodule

// File: tests/tb_clock_gen.sv
// testbench clock and reset source
// free-running clock, reset held low for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 5
)
(
   output logic CLK,
   output logic rst_n
);

   initial
   begin
      CLK = 1'b0;
      forever
         #(PERIOD_NS / 2) CLK = ~CLK;
   end

   // release on a rising edge, after the flops have seen it low
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge CLK);
      rst_n <= 1'b1;
   end

endmodule

// File: tests/tb_mem_subsys.sv
// testbench for the main memory subsystem
// replays the golden access list, checks DO one edge after every cycle

`timescale 1ns/1ps

module tb_mem_subsys;

   localparam int          CLK_PERIOD   = 20;
   localparam int          RESET_CYCLES = 5;
   localparam int          WD_MARGIN    = 20;
   localparam string       GOLDEN_FILE  = "tests/mem_golden.txt";
   localparam logic [31:0] LCG_SEED     = 32'h5acc6fdc;

   // access kinds as coded in the golden file
   localparam int K_IDLE    = 0;
   localparam int K_RD_WORD = 1;
   localparam int K_RD_BYTE = 2;
   localparam int K_WR_WORD = 3;
   localparam int K_WR_BYTE = 4;
   // added to a kind, no idle gap before that access
   localparam int K_CHAIN   = 8;

   logic        CLK;
   logic        rst_n;
   logic [15:0] A;
   logic [15:0] DI;
   logic        CE_N;
   logic        WE_N;
   logic        BYTE_OP;
   logic [15:0] DO;

   int          kind_q[$];
   bit          chain_q[$];
   logic [15:0] addr_q[$];
   logic [15:0] data_q[$];
   logic [15:0] exp_q[$];

   int          wd_cycles = 0;
   logic [31:0] lcg_state = LCG_SEED;
   logic [15:0] pend_exp;
   string       pend_name;

   tb_clock_gen
   #(
      .PERIOD_NS    (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   )
   u_clk
   (
      .CLK   (CLK),
      .rst_n (rst_n)
   );

   mem_subsys u_dut
   (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .A       (A),
      .DI      (DI),
      .CE_N    (CE_N),
      .WE_N    (WE_N),
      .BYTE_OP (BYTE_OP),
      .DO      (DO)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic string kind_name(input int kind);
      case (kind)
         K_IDLE:    return "idle";
         K_RD_WORD: return "read word";
         K_RD_BYTE: return "read byte";
         K_WR_WORD: return "write word";
         K_WR_BYTE: return "write byte";
         default:   return "unknown";
      endcase
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected)
         stop_run($sformatf("error: %s expected %06o actual %06o", name, expected, actual));
   endtask

   // comment lines start with a slash, every other line is one access
   task automatic load_golden();
      int               fd;
      int               r;
      int               c;
      bit               done;
      logic [31:0]      f_kind;
      logic [31:0]      f_addr;
      logic [31:0]      f_data;
      logic [31:0]      f_exp;
      logic [8*256-1:0] rest;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0)
         stop_run({"cannot open the golden file ", GOLDEN_FILE});
      done = 1'b0;
      while (!done)
      begin
         r = $fscanf(fd, " %o %o %o %o", f_kind, f_addr, f_data, f_exp);
         if (r == 4)
         begin
            if ((f_kind & 7) > K_WR_BYTE)
               stop_run("golden file holds an unknown access kind");
            kind_q.push_back(int'(f_kind & 7));
            chain_q.push_back((f_kind & K_CHAIN) != 0);
            addr_q.push_back(f_addr[15:0]);
            data_q.push_back(f_data[15:0]);
            exp_q.push_back(f_exp[15:0]);
         end
         else if (r == 0)
         begin
            c = $fgetc(fd);
            if (c != "/")
               stop_run("golden file has a line that is neither an access nor a comment");
            r = $fgets(rest, fd);
         end
         else if (r > 0)
            stop_run("golden file has an access line with missing fields");
         else
            done = 1'b1;
      end
      $fclose(fd);
      if (kind_q.size() == 0)
         stop_run("golden file holds no accesses");
   endtask

   // drive one bus cycle, then check the result of the cycle before it
   task automatic run_cycle(input int kind, input logic [15:0] addr,
                            input logic [15:0] data, input logic [15:0] expected,
                            input string name);
      @(posedge CLK);
      CE_N    <= (kind == K_IDLE);
      WE_N    <= !((kind == K_WR_WORD) || (kind == K_WR_BYTE));
      BYTE_OP <= (kind == K_RD_BYTE) || (kind == K_WR_BYTE);
      A       <= addr;
      DI      <= data;
      @(negedge CLK);
      check_value(pend_name, pend_exp, DO);
      pend_exp  = expected;
      pend_name = name;
   endtask

   // watchdog, at most three cycles per access
   initial
   begin
      wait (wd_cycles != 0);
      repeat (wd_cycles) @(posedge CLK);
      stop_run("watchdog expired, the simulation did not finish in time");
   end

   initial
   begin
      int    gap;
      string name;
      CE_N      = 1'b1;
      WE_N      = 1'b1;
      BYTE_OP   = 1'b0;
      A         = '0;
      DI        = '0;
      pend_exp  = '0;
      pend_name = "DO after reset";

      load_golden();
      wd_cycles = RESET_CYCLES + 3 * kind_q.size() + WD_MARGIN;

      wait (rst_n === 1'b1);
      for (int i = 0; i < kind_q.size(); i++)
      begin
         if (!chain_q[i])
         begin
            lcg_state = lcg_next(lcg_state);
            gap = int'(lcg_state[31:16] % 3);
            repeat (gap)
               run_cycle(K_IDLE, '0, '0, '0, $sformatf("idle gap before access %0d", i));
         end
         name = $sformatf("access %0d %s at %06o", i, kind_name(kind_q[i]), addr_q[i]);
         run_cycle(kind_q[i], addr_q[i], data_q[i], exp_q[i], name);
      end

      // flush the last result and see DO return to zero
      run_cycle(K_IDLE, '0, '0, '0, "final idle");
      run_cycle(K_IDLE, '0, '0, '0, "final idle");

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: vlog.f
verilog/mem_cfg_pkg.sv
verilog/bus_op_pkg.sv
verilog/bus_decode.sv
verilog/ram_bank.sv
verilog/read_steer.sv
verilog/mem_subsys.sv
tests/tb_clock_gen.sv
tests/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  # packages first, the RTL modules import them
  - verilog/mem_cfg_pkg.sv
  - verilog/bus_op_pkg.sv
  - verilog/bus_decode.sv
  - verilog/ram_bank.sv
  - verilog/read_steer.sv
  - verilog/mem_subsys.sv

  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_mem_subsys.sv

// File: tests/mem_golden.txt
// kind addr wdata expected_DO, all octal; expected is DO the cycle after
// kind 0 idle 1 rd word 2 rd byte 3 wr word 4 wr byte, plus 10 for no gap before
3 000000 012345 000000
3 037776 054321 000000
3 040000 123456 000000
3 077776 165432 000000
3 100000 007070 000000
3 137776 170707 000000
3 140000 111111 000000
3 177776 177777 000000
1 000000 000000 012345
11 037776 000000 054321
11 040000 000000 123456
11 077776 000000 165432
11 100000 000000 007070
11 137776 000000 170707
11 140000 000000 111111
11 177776 000000 177777
11 000001 000000 012345
3 002000 000001 000000
3 042000 000002 000000
3 102000 000003 000000
3 142000 000004 000000
1 002000 000000 000001
11 042000 000000 000002
11 102000 000000 000003
11 142000 000000 000004
3 010000 125252 000000
4 010001 177463 000000
1 010000 000000 031652
4 010000 000125 000000
1 010000 000000 031525
2 010001 000000 000063
12 010000 000000 000125
12 040001 000000 000247
12 040000 000000 000056
0 000000 000000 000000
3 020000 054545 000000
11 020000 000000 054545
14 020001 000377 000000
12 020001 000000 000377
11 020000 000000 177545
0 177777 000000 000000
1 177776 000000 177777
